/* src.f */
rtl/slam_ctrl_pkg.sv
rtl/slam_data_pkg.sv
rtl/stage_ctrl.sv
rtl/nl_capture.sv
rtl/state_bank.sv
rtl/slam_stage_core.sv
sim/nl_unit_model.sv
sim/tb_slam_stage_core.sv

/* sim/tb_slam_stage_core.sv */
`timescale 1ns/1ps

module tb_slam_stage_core
  import slam_ctrl_pkg::*;
  import slam_data_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int RST_CYCLES    = 8;
  localparam int MAX_STAGES    = 60;
  localparam int STAGE_CYCLES  = 12;
  localparam int M_IDLE        = 0;
  localparam int M_RUN         = 1;
  localparam int M_COMMIT      = 2;

  logic                clk;
  logic                sys_rst;
  logic [STG_W-1:0]    stage_val;
  logic [STG_W-1:0]    stage_rdy;
  logic [LM_IDX_W-1:0] l_k;
  logic                init_predict;
  logic                init_newlm;
  logic                init_update;
  logic                done_predict;
  logic                done_newlm;
  logic                done_update;
  logic [STG_W-1:0]    extra_done;
  logic [STG_W-1:0]    done_vec;
  pose_t               pose;
  landmark_t           lm;
  nl_result_t          result;

  // reference model state
  int                  m_state;
  logic [STG_W-1:0]    m_kind;
  logic [LM_IDX_W-1:0] m_idx;
  logic [STG_W-1:0]    exp_init;
  logic [STG_W-1:0]    exp_rdy;
  nl_result_t          m_res;
  pose_t               ref_pose;
  landmark_t           ref_lm [LM_DEPTH];
  int                  err_cnt = 0;
  int                  stage_cnt = 0;

  slam_stage_core dut0 (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (stage_val),
    .o_stage_rdy    (stage_rdy),
    .i_l_k          (l_k),
    .o_init_predict (init_predict),
    .o_init_newlm   (init_newlm),
    .o_init_update  (init_update),
    .o_pose         (pose),
    .o_lm           (lm),
    .i_done_predict (done_predict),
    .i_done_newlm   (done_newlm),
    .i_done_update  (done_update),
    .i_result       (result)
  );

  nl_unit_model u_nl_model (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_init_predict (init_predict),
    .i_init_newlm   (init_newlm),
    .i_init_update  (init_update),
    .i_extra_done   (extra_done),
    .o_done_predict (done_predict),
    .o_done_newlm   (done_newlm),
    .o_done_update  (done_update),
    .o_result       (result)
  );

  assign done_vec = {done_update, done_newlm, done_predict};

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic log_error(input string msg);
    err_cnt++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  // expected sequence of accept, done, commit and ready
  always @(posedge clk) begin
    if (sys_rst) begin
      m_state  <= M_IDLE;
      m_kind   <= '0;
      m_idx    <= '0;
      exp_init <= '0;
      exp_rdy  <= '0;
      ref_pose <= '0;
      for (int i = 0; i < LM_DEPTH; i++) begin
        ref_lm[i] <= '0;
      end
    end else begin
      exp_init <= '0;
      exp_rdy  <= '0;
      case (m_state)
        M_IDLE: begin
          // single bit only, never in the ready cycle
          if (exp_rdy == '0 && $onehot(stage_val)) begin
            m_state  <= M_RUN;
            m_kind   <= stage_val;
            m_idx    <= l_k;
            exp_init <= stage_val;
          end
        end
        M_RUN: begin
          if ((done_vec & m_kind) != '0) begin
            m_state <= M_COMMIT;
            m_res   <= result;
          end
        end
        default: begin
          m_state <= M_IDLE;
          exp_rdy <= m_kind;
          if (m_kind[STG_PRD_BIT]) begin
            ref_pose.x       <= ref_pose.x + m_res.result_2;
            ref_pose.y       <= ref_pose.y + m_res.result_3;
            ref_pose.heading <= ref_pose.heading + m_res.result_1;
          end else if (m_kind[STG_NEW_BIT]) begin
            ref_lm[m_idx] <= '{lx: m_res.result_0, ly: m_res.result_1};
          end else begin
            ref_pose.x       <= ref_pose.x + m_res.result_0;
            ref_pose.y       <= ref_pose.y + m_res.result_1;
            ref_pose.heading <= ref_pose.heading + m_res.result_2;
            ref_lm[m_idx].lx <= ref_lm[m_idx].lx + m_res.result_3;
            ref_lm[m_idx].ly <= ref_lm[m_idx].ly + m_res.result_4;
          end
        end
      endcase
    end
  end

  // init strobes only in the cycle after accept
  a_init_match: assert property (@(posedge clk) disable iff (sys_rst)
    {init_update, init_newlm, init_predict} == exp_init)
    else log_error("init strobes differ from expected");

  // ready bit two edges after the sampled done
  a_rdy_match: assert property (@(posedge clk) disable iff (sys_rst)
    stage_rdy == exp_rdy)
    else log_error("stage ready differs from expected");

  // pose moves only by the commit rules
  a_pose_match: assert property (@(posedge clk) disable iff (sys_rst)
    pose == ref_pose)
    else log_error("pose differs from reference");

  // entry at the latched index
  a_lm_match: assert property (@(posedge clk) disable iff (sys_rst)
    lm == ref_lm[m_idx])
    else log_error("landmark differs from reference");

  // one full stage with optional stray dones for the other kinds
  task automatic run_stage(input logic [STG_W-1:0] req, input logic [LM_IDX_W-1:0] idx,
                           input logic noise);
    @(negedge clk);
    stage_val = req;
    l_k       = idx;
    @(negedge clk);
    if (noise) begin
      extra_done = ~req;
    end
    @(negedge clk);
    extra_done = '0;
    while ((stage_rdy & req) == '0) begin
      @(negedge clk);
    end
    // request still high at the edge closing the ready cycle
    @(negedge clk);
    stage_val = '0;
    stage_cnt++;
  endtask

  // zero or multi-bit level that must be ignored
  task automatic hold_bad_request(input logic [STG_W-1:0] req, input int cycles);
    @(negedge clk);
    stage_val = req;
    repeat (cycles) begin
      @(negedge clk);
    end
    stage_val = '0;
  endtask

  task automatic pulse_stray_dones();
    @(negedge clk);
    extra_done = '1;
    @(negedge clk);
    extra_done = '0;
  endtask

  initial begin : stimulus
    sys_rst    = 1'b1;
    stage_val  = '0;
    l_k        = '0;
    extra_done = '0;
    repeat (RST_CYCLES) begin
      @(posedge clk);
    end
    @(negedge clk);
    sys_rst = 1'b0;
    assert ({init_update, init_newlm, init_predict} == '0 && stage_rdy == '0 &&
            pose == '0 && lm == '0)
      else log_error("outputs not cleared by reset");
    // new landmark at 3 and update on 5 before 3 is read again
    run_stage(3'b010, 4'd3, 1'b0);
    run_stage(3'b100, 4'd5, 1'b1);
    run_stage(3'b001, 4'd3, 1'b0);
    run_stage(3'b100, 4'd3, 1'b1);
    hold_bad_request(3'b011, 3);
    hold_bad_request(3'b111, 2);
    hold_bad_request(3'b000, 2);
    pulse_stray_dones();
    for (int i = 0; i < 48; i++) begin
      run_stage(STG_W'(1 << (i % 3)), LM_IDX_W'(i * 5 + 3), i[0]);
    end
    repeat (4) begin
      @(negedge clk);
    end
    $display("checks done, %0d stages, %0d errors", stage_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // budget of worst case stages plus reset
  initial begin : watchdog
    #((MAX_STAGES * STAGE_CYCLES + RST_CYCLES) * CLK_PERIOD);
    $display("watchdog timeout, stimulus did not complete after %0d stages", stage_cnt);
    $display("Regression failed");
    $finish;
  end

endmodule

/* sim/nl_unit_model.sv */
`timescale 1ns/1ps

module nl_unit_model
  import slam_ctrl_pkg::*;
  import slam_data_pkg::*;
(
  input  logic             clk,
  input  logic             sys_rst,
  input  logic             i_init_predict,
  input  logic             i_init_newlm,
  input  logic             i_init_update,
  // stray dones from the testbench, or-ed onto the outputs
  input  logic [STG_W-1:0] i_extra_done,
  output logic             o_done_predict,
  output logic             o_done_newlm,
  output logic             o_done_update,
  output nl_result_t       o_result
);

  localparam logic [31:0] LFSR_SEED = 32'hed868f03;
  // x^32 + x^22 + x^2 + x + 1, right shifting form
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic [31:0]      lfsr = LFSR_SEED;
  logic [STG_W-1:0] pend = '0;
  logic [STG_W-1:0] done_q = '0;
  int               wait_cnt = 0;

  // one Galois step
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  // one step per bit taken, lsb first
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  initial begin
    o_result = '0;
  end

  // inits change on the rising edge, so they are stable here
  always @(negedge clk) begin : answer
    logic [31:0] w;
    done_q = '0;
    if (sys_rst) begin
      pend     = '0;
      wait_cnt = 0;
    end else if (pend != '0) begin
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        done_q = pend;
        pend   = '0;
      end
    end else if (i_init_predict || i_init_newlm || i_init_update) begin
      pend = {i_init_update, i_init_newlm, i_init_predict};
      // latency of 1 to 8 cycles
      take_bits(3, w);
      wait_cnt = int'(w) + 1;
    end
    // fresh words every cycle, only the done cycle should matter
    take_bits(32, w);
    o_result.result_0 = w;
    take_bits(32, w);
    o_result.result_1 = w;
    take_bits(32, w);
    o_result.result_2 = w;
    take_bits(32, w);
    o_result.result_3 = w;
    take_bits(32, w);
    o_result.result_4 = w;
  end

  assign o_done_predict = done_q[STG_PRD_BIT] | i_extra_done[STG_PRD_BIT];
  assign o_done_newlm   = done_q[STG_NEW_BIT] | i_extra_done[STG_NEW_BIT];
  assign o_done_update  = done_q[STG_UPD_BIT] | i_extra_done[STG_UPD_BIT];

endmodule

/* rtl/slam_stage_core.sv */
`timescale 1ns/1ps

module slam_stage_core
  import slam_ctrl_pkg::*;
  import slam_data_pkg::*;
(
  input  logic                clk,
  input  logic                sys_rst,
  // processor side
  input  logic [STG_W-1:0]    i_stage_val,
  output logic [STG_W-1:0]    o_stage_rdy,
  input  logic [LM_IDX_W-1:0] i_l_k,
  // toward the nonlinear unit
  output logic                o_init_predict,
  output logic                o_init_newlm,
  output logic                o_init_update,
  output pose_t               o_pose,
  output landmark_t           o_lm,
  // from the nonlinear unit
  input  logic                i_done_predict,
  input  logic                i_done_newlm,
  input  logic                i_done_update,
  input  nl_result_t          i_result
);

  stage_e  stage;
  logic    accept;
  logic    capture;
  commit_t commit;

  // sequencer, owns every strobe
  stage_ctrl u_stage_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update),
    .o_stage        (stage),
    .o_accept       (accept),
    .o_capture      (capture),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_init_update  (o_init_update),
    .o_stage_rdy    (o_stage_rdy)
  );

  // results to commit record, one cycle after done
  nl_capture u_nl_capture (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_capture (capture),
    .i_stage   (stage),
    .i_result  (i_result),
    .o_commit  (commit)
  );

  // pose and landmark storage
  // outputs feed the nonlinear unit directly
  state_bank u_state_bank (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .i_accept (accept),
    .i_l_k    (i_l_k),
    .i_commit (commit),
    .o_pose   (o_pose),
    .o_lm     (o_lm)
  );

endmodule

/* rtl/state_bank.sv */
`timescale 1ns/1ps

module state_bank
  import slam_ctrl_pkg::*;
  import slam_data_pkg::*;
(
  input  logic                clk,
  input  logic                sys_rst,
  input  logic                i_accept,
  input  logic [LM_IDX_W-1:0] i_l_k,
  input  commit_t             i_commit,
  output pose_t               o_pose,
  output landmark_t           o_lm
);

  pose_t               pose_q;
  landmark_t           lm_tab [LM_DEPTH];
  logic [LM_IDX_W-1:0] idx_q;

  // index of the landmark for this stage
  // held from accept until the next accept
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      idx_q <= '0;
    end else if (i_accept) begin
      idx_q <= i_l_k;
    end
  end

  // pose register
  // predict and update both add, wrapping at 32 bits
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      pose_q <= '0;
    end else if (i_commit.valid) begin
      case (i_commit.kind)
        ST_PRD, ST_UPD: begin
          pose_q.x       <= pose_q.x + i_commit.pose.x;
          pose_q.y       <= pose_q.y + i_commit.pose.y;
          pose_q.heading <= pose_q.heading + i_commit.pose.heading;
        end
        default: begin
          pose_q <= pose_q;
        end
      endcase
    end
  end

  // landmark table, 16 entries
  // new landmark overwrites, update adds
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < LM_DEPTH; i++) begin
        lm_tab[i] <= '0;
      end
    end else if (i_commit.valid) begin
      case (i_commit.kind)
        ST_NEW: begin
          lm_tab[idx_q] <= i_commit.lm;
        end
        ST_UPD: begin
          lm_tab[idx_q].lx <= lm_tab[idx_q].lx + i_commit.lm.lx;
          lm_tab[idx_q].ly <= lm_tab[idx_q].ly + i_commit.lm.ly;
        end
        default: begin
          lm_tab[idx_q] <= lm_tab[idx_q];
        end
      endcase
    end
  end

  // reads follow the latched index
  assign o_pose = pose_q;
  assign o_lm   = lm_tab[idx_q];

  // sequencer only accepts while idle
  // so the index never moves under a pending commit
  a_no_commit_on_accept: assert property (@(posedge clk) disable iff (sys_rst)
    !(i_accept && i_commit.valid));

endmodule

/* rtl/nl_capture.sv */
`timescale 1ns/1ps

module nl_capture
  import slam_ctrl_pkg::*;
  import slam_data_pkg::*;
(
  input  logic       clk,
  input  logic       sys_rst,
  input  logic       i_capture,
  input  stage_e     i_stage,
  input  nl_result_t i_result,
  output commit_t    o_commit
);

  pose_t     pose_d;
  landmark_t lm_d;
  logic      valid_q;
  stage_e    kind_q;
  pose_t     pose_q;
  landmark_t lm_q;

  // route result words by stage
  // unused fields stay zero
  always_comb begin
    pose_d = '0;
    lm_d   = '0;
    case (i_stage)
      ST_PRD: begin
        // odometry deltas
        pose_d.x       = i_result.result_2;
        pose_d.y       = i_result.result_3;
        pose_d.heading = i_result.result_1;
      end
      ST_NEW: begin
        // absolute position of the new landmark
        lm_d.lx = i_result.result_0;
        lm_d.ly = i_result.result_1;
      end
      ST_UPD: begin
        // correction for pose and the observed landmark
        pose_d.x       = i_result.result_0;
        pose_d.y       = i_result.result_1;
        pose_d.heading = i_result.result_2;
        lm_d.lx        = i_result.result_3;
        lm_d.ly        = i_result.result_4;
      end
      default: begin
        pose_d = '0;
        lm_d   = '0;
      end
    endcase
  end

  // valid lasts one cycle per capture
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_capture;
    end
  end

  // payload only moves on capture
  always_ff @(posedge clk) begin
    if (i_capture) begin
      kind_q <= i_stage;
      pose_q <= pose_d;
      lm_q   <= lm_d;
    end
  end

  assign o_commit = '{valid: valid_q, kind: kind_q, pose: pose_q, lm: lm_q};

  // a live record always names a real stage
  a_commit_kind: assert property (@(posedge clk) disable iff (sys_rst)
    o_commit.valid |-> (o_commit.kind != ST_IDLE));

endmodule

/* rtl/stage_ctrl.sv */
`timescale 1ns/1ps

module stage_ctrl
  import slam_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             sys_rst,
  input  logic [STG_W-1:0] i_stage_val,
  input  logic             i_done_predict,
  input  logic             i_done_newlm,
  input  logic             i_done_update,
  output stage_e           o_stage,
  output logic             o_accept,
  output logic             o_capture,
  output logic             o_init_predict,
  output logic             o_init_newlm,
  output logic             o_init_update,
  output logic [STG_W-1:0] o_stage_rdy
);

  fsm_e             state;
  stage_e           req_stage;
  logic             done_sel;
  logic [STG_W-1:0] rdy_sel;

  // decode the request level
  // anything but a single set bit stays ST_IDLE and is ignored
  always_comb begin
    req_stage = ST_IDLE;
    if (i_stage_val == STG_W'(1 << STG_PRD_BIT)) begin
      req_stage = ST_PRD;
    end else if (i_stage_val == STG_W'(1 << STG_NEW_BIT)) begin
      req_stage = ST_NEW;
    end else if (i_stage_val == STG_W'(1 << STG_UPD_BIT)) begin
      req_stage = ST_UPD;
    end
  end

  // only the done of the active stage counts
  always_comb begin
    case (o_stage)
      ST_PRD:  done_sel = i_done_predict;
      ST_NEW:  done_sel = i_done_newlm;
      ST_UPD:  done_sel = i_done_update;
      default: done_sel = 1'b0;
    endcase
  end

  // ready bit matching the active stage
  always_comb begin
    rdy_sel = '0;
    case (o_stage)
      ST_PRD:  rdy_sel[STG_PRD_BIT] = 1'b1;
      ST_NEW:  rdy_sel[STG_NEW_BIT] = 1'b1;
      ST_UPD:  rdy_sel[STG_UPD_BIT] = 1'b1;
      default: rdy_sel = '0;
    endcase
  end

  // no accept in the ready cycle
  // processor has not dropped its request yet
  assign o_accept  = (state == FSM_IDLE) && (o_stage_rdy == '0) && (req_stage != ST_IDLE);
  // results are sampled in the same cycle as done
  assign o_capture = (state == FSM_RUN) && done_sel;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state          <= FSM_IDLE;
      o_stage        <= ST_IDLE;
      o_init_predict <= 1'b0;
      o_init_newlm   <= 1'b0;
      o_init_update  <= 1'b0;
      o_stage_rdy    <= '0;
    end else begin
      // strobes default low and last one cycle
      o_init_predict <= 1'b0;
      o_init_newlm   <= 1'b0;
      o_init_update  <= 1'b0;
      o_stage_rdy    <= '0;
      case (state)
        FSM_IDLE: begin
          if (o_accept) begin
            state          <= FSM_RUN;
            o_stage        <= req_stage;
            o_init_predict <= (req_stage == ST_PRD);
            o_init_newlm   <= (req_stage == ST_NEW);
            o_init_update  <= (req_stage == ST_UPD);
          end
        end
        FSM_RUN: begin
          // wait here for the nonlinear unit as long as it takes
          if (o_capture) begin
            state <= FSM_COMMIT;
          end
        end
        FSM_COMMIT: begin
          // state bank applies the record at this edge
          state       <= FSM_IDLE;
          o_stage     <= ST_IDLE;
          o_stage_rdy <= rdy_sel;
        end
        default: begin
          state <= FSM_IDLE;
        end
      endcase
    end
  end

  // at most one init strobe toward the nonlinear unit
  a_init_onehot: assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0({o_init_predict, o_init_newlm, o_init_update}));

  // at most one ready bit back to the processor
  a_rdy_onehot: assert property (@(posedge clk) disable iff (sys_rst)
    $onehot0(o_stage_rdy));

  // stage kind stays set while the sequencer is busy
  // so capture and ready always see a real stage
  a_stage_busy: assert property (@(posedge clk) disable iff (sys_rst)
    (state != FSM_IDLE) |-> (o_stage != ST_IDLE));

endmodule

/* rtl/slam_data_pkg.sv */
package slam_data_pkg;

  // stage kind travels inside the commit record
  import slam_ctrl_pkg::*;

  // word width of every coordinate and result
  localparam int DATA_W   = 32;
  // landmark index and table depth
  localparam int LM_IDX_W = 4;
  localparam int LM_DEPTH = 1 << LM_IDX_W;

  // robot pose, three words
  typedef struct packed {
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] y;
    logic [DATA_W-1:0] heading;
  } pose_t;

  // one landmark entry
  typedef struct packed {
    logic [DATA_W-1:0] lx;
    logic [DATA_W-1:0] ly;
  } landmark_t;

  // nonlinear unit results, result_0 in the low word
  typedef struct packed {
    logic [DATA_W-1:0] result_4;
    logic [DATA_W-1:0] result_3;
    logic [DATA_W-1:0] result_2;
    logic [DATA_W-1:0] result_1;
    logic [DATA_W-1:0] result_0;
  } nl_result_t;

  // routed results ready to be applied by the state bank
  typedef struct packed {
    logic      valid;
    stage_e    kind;
    pose_t     pose;
    landmark_t lm;
  } commit_t;

endpackage

/* rtl/slam_ctrl_pkg.sv */
package slam_ctrl_pkg;

  // kind of filter stage in flight
  // ST_IDLE doubles as "no stage"
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_PRD  = 2'd1,
    ST_NEW  = 2'd2,
    ST_UPD  = 2'd3
  } stage_e;

  // sequencer states
  // run covers init pulse and the wait for done
  // commit is the single cycle where the state bank applies results
  typedef enum logic [1:0] {
    FSM_IDLE   = 2'd0,
    FSM_RUN    = 2'd1,
    FSM_COMMIT = 2'd2
  } fsm_e;

  // bit positions inside stage_val / stage_rdy
  localparam int STG_PRD_BIT = 0;
  localparam int STG_NEW_BIT = 1;
  localparam int STG_UPD_BIT = 2;

  // width of the request and ready vectors
  localparam int STG_W = 3;

endpackage
